// File: common/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    // data, address and instruction values.
    typedef logic [15:0] lc3b_word;

    // register file index.
    typedef logic [2:0] lc3b_reg;

    // opcode field, bits 15:12 of the instruction.
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // immediate for add and and.
    typedef logic [4:0] lc3b_imm5;

    // word offset for ldr and str.
    typedef logic [5:0] lc3b_offset6;

    // pc-relative word offset for br.
    typedef logic [8:0] lc3b_offset9;

    // condition codes, n in bit 2.
    typedef logic [2:0] lc3b_nzp;

endpackage : lc3b_isa_pkg

// File: common/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    // alu operation, alu_add is the idle value.
    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // second alu operand.
    typedef logic [1:0] lc3b_alumux_sel;

    localparam lc3b_alumux_sel alumux_regb    = 2'b00;
    localparam lc3b_alumux_sel alumux_offset6 = 2'b01;
    localparam lc3b_alumux_sel alumux_imm5    = 2'b11;

    // writeback value.
    typedef logic lc3b_regfilemux_sel;

    localparam lc3b_regfilemux_sel regfilemux_alu = 1'b0;
    localparam lc3b_regfilemux_sel regfilemux_mem = 1'b1;

endpackage : lc3b_ctrl_pkg

// File: src/control_rom.sv
`timescale 1ns/100ps

module control_rom (
    input  lc3b_isa_pkg::lc3b_opcode          opcode,
    input  logic                              imm_enable,
    output logic                              load_regfile,
    output logic                              load_cc,
    output logic                              brmux_sel,
    output logic                              storemux_sel,
    output lc3b_ctrl_pkg::lc3b_regfilemux_sel regfilemux_sel,
    output logic                              mem_read,
    output logic                              mem_write,
    output lc3b_ctrl_pkg::lc3b_aluop          aluop,
    output lc3b_ctrl_pkg::lc3b_alumux_sel     alumux_sel
);

    always_comb begin
        // everything idle unless the opcode asks.
        load_regfile   = 1'b0;
        load_cc        = 1'b0;
        brmux_sel      = 1'b0;
        storemux_sel   = 1'b0;
        regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        aluop          = lc3b_ctrl_pkg::alu_add;
        alumux_sel     = lc3b_ctrl_pkg::alumux_regb;

        case (opcode)
            lc3b_isa_pkg::op_add: begin
                aluop        = lc3b_ctrl_pkg::alu_add;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                // immediate form.
                if (imm_enable) begin
                    alumux_sel = lc3b_ctrl_pkg::alumux_imm5;
                end
            end

            lc3b_isa_pkg::op_and: begin
                aluop        = lc3b_ctrl_pkg::alu_and;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                if (imm_enable) begin
                    alumux_sel = lc3b_ctrl_pkg::alumux_imm5;
                end
            end

            lc3b_isa_pkg::op_not: begin
                aluop        = lc3b_ctrl_pkg::alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end

            lc3b_isa_pkg::op_ldr: begin
                // base plus offset6 scaled to words.
                aluop          = lc3b_ctrl_pkg::alu_add;
                alumux_sel     = lc3b_ctrl_pkg::alumux_offset6;
                mem_read       = 1'b1;
                // loaded word goes to dr.
                regfilemux_sel = lc3b_ctrl_pkg::regfilemux_mem;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end

            lc3b_isa_pkg::op_str: begin
                aluop        = lc3b_ctrl_pkg::alu_add;
                alumux_sel   = lc3b_ctrl_pkg::alumux_offset6;
                // sr sits in bits 11:9, read on port b.
                storemux_sel = 1'b1;
                mem_write    = 1'b1;
            end

            lc3b_isa_pkg::op_br: begin
                brmux_sel = 1'b1;
            end

            default: begin
                // unknown opcodes keep the idle set.
                load_regfile   = 1'b0;
                load_cc        = 1'b0;
                brmux_sel      = 1'b0;
                storemux_sel   = 1'b0;
                regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
                mem_read       = 1'b0;
                mem_write      = 1'b0;
                aluop          = lc3b_ctrl_pkg::alu_add;
                alumux_sel     = lc3b_ctrl_pkg::alumux_regb;
            end
        endcase
    end

endmodule : control_rom

// File: src/regfile.sv
`timescale 1ns/100ps

module regfile #(
    parameter int num_regs = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    input  lc3b_isa_pkg::lc3b_reg    dest,
    input  lc3b_isa_pkg::lc3b_word   in,
    input  lc3b_isa_pkg::lc3b_reg    src_a,
    input  lc3b_isa_pkg::lc3b_reg    src_b,
    output lc3b_isa_pkg::lc3b_word   reg_a,
    output lc3b_isa_pkg::lc3b_word   reg_b
);

    lc3b_isa_pkg::lc3b_word data [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // same-cycle write shows through to the decode read.
    assign reg_a = (load && (dest == src_a)) ? in : data[src_a];
    assign reg_b = (load && (dest == src_b)) ? in : data[src_b];

endmodule : regfile

// File: src/alu.sv
`timescale 1ns/100ps

module alu (
    input  lc3b_ctrl_pkg::lc3b_aluop aluop,
    input  lc3b_isa_pkg::lc3b_word   a,
    input  lc3b_isa_pkg::lc3b_word   b,
    output lc3b_isa_pkg::lc3b_word   f
);

    always_comb begin
        case (aluop)
            lc3b_ctrl_pkg::alu_add:  f = a + b;
            lc3b_ctrl_pkg::alu_and:  f = a & b;
            lc3b_ctrl_pkg::alu_not:  f = ~a;
            lc3b_ctrl_pkg::alu_pass: f = b;
            default:                 f = a + b;
        endcase
    end

endmodule : alu

// File: src/lc3b_datapath.sv
`timescale 1ns/100ps

module lc3b_datapath #(
    parameter lc3b_isa_pkg::lc3b_word reset_pc = 16'h0000,
    parameter int                     num_regs = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  lc3b_isa_pkg::lc3b_word            imem_rdata,
    input  lc3b_isa_pkg::lc3b_word            dmem_rdata,
    input  logic                              load_regfile,
    input  logic                              load_cc,
    input  logic                              brmux_sel,
    input  logic                              storemux_sel,
    input  lc3b_ctrl_pkg::lc3b_regfilemux_sel regfilemux_sel,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  lc3b_ctrl_pkg::lc3b_aluop          aluop,
    input  lc3b_ctrl_pkg::lc3b_alumux_sel     alumux_sel,
    output lc3b_isa_pkg::lc3b_opcode          opcode,
    output logic                              imm_enable,
    output lc3b_isa_pkg::lc3b_word            imem_address,
    output lc3b_isa_pkg::lc3b_word            dmem_address,
    output lc3b_isa_pkg::lc3b_word            dmem_wdata,
    output logic                              dmem_read,
    output logic                              dmem_write
);

    lc3b_isa_pkg::lc3b_word pc;
    lc3b_isa_pkg::lc3b_word pc_plus2;
    lc3b_isa_pkg::lc3b_word br_target;
    logic                   br_taken;

    // fetch/decode.
    lc3b_isa_pkg::lc3b_word if_id_pc;
    lc3b_isa_pkg::lc3b_word if_id_ir;

    // decode/execute.
    lc3b_isa_pkg::lc3b_word            id_ex_pc;
    lc3b_isa_pkg::lc3b_word            id_ex_ir;
    lc3b_isa_pkg::lc3b_word            id_ex_reg_a;
    lc3b_isa_pkg::lc3b_word            id_ex_reg_b;
    logic                              id_ex_load_regfile;
    logic                              id_ex_load_cc;
    logic                              id_ex_brmux_sel;
    lc3b_ctrl_pkg::lc3b_regfilemux_sel id_ex_regfilemux_sel;
    logic                              id_ex_mem_read;
    logic                              id_ex_mem_write;
    lc3b_ctrl_pkg::lc3b_aluop          id_ex_aluop;
    lc3b_ctrl_pkg::lc3b_alumux_sel     id_ex_alumux_sel;

    // execute/memory.
    lc3b_isa_pkg::lc3b_word            ex_mem_alu;
    lc3b_isa_pkg::lc3b_word            ex_mem_wdata;
    lc3b_isa_pkg::lc3b_reg             ex_mem_dest;
    logic                              ex_mem_load_regfile;
    logic                              ex_mem_load_cc;
    lc3b_ctrl_pkg::lc3b_regfilemux_sel ex_mem_regfilemux_sel;
    logic                              ex_mem_mem_read;
    logic                              ex_mem_mem_write;

    // memory/writeback.
    lc3b_isa_pkg::lc3b_word            mem_wb_alu;
    lc3b_isa_pkg::lc3b_word            mem_wb_rdata;
    lc3b_isa_pkg::lc3b_reg             mem_wb_dest;
    logic                              mem_wb_load_regfile;
    logic                              mem_wb_load_cc;
    lc3b_ctrl_pkg::lc3b_regfilemux_sel mem_wb_regfilemux_sel;

    lc3b_isa_pkg::lc3b_reg     src_b;
    lc3b_isa_pkg::lc3b_word    reg_a;
    lc3b_isa_pkg::lc3b_word    reg_b;
    lc3b_isa_pkg::lc3b_imm5    imm5;
    lc3b_isa_pkg::lc3b_offset6 offset6;
    lc3b_isa_pkg::lc3b_offset9 offset9;
    lc3b_isa_pkg::lc3b_word    alu_b;
    lc3b_isa_pkg::lc3b_word    alu_f;
    lc3b_isa_pkg::lc3b_word    wb_value;
    lc3b_isa_pkg::lc3b_nzp     cc;
    lc3b_isa_pkg::lc3b_nzp     new_cc;

    // fetch.
    assign imem_address = pc;
    assign pc_plus2     = pc + 16'd2;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (br_taken) begin
            pc <= br_target;
        end else begin
            pc <= pc_plus2;
        end
    end

    // a zero ir is br with no condition bits, the no-op.
    always_ff @(posedge clk) begin
        if (reset || br_taken) begin
            if_id_ir <= '0;
        end else begin
            if_id_ir <= imem_rdata;
        end
        if_id_pc <= pc;
    end

    // decode.
    assign opcode     = lc3b_isa_pkg::lc3b_opcode'(if_id_ir[15:12]);
    assign imm_enable = if_id_ir[5];
    // str reads its source through port b.
    assign src_b      = storemux_sel ? if_id_ir[11:9] : if_id_ir[2:0];

    regfile #(
        .num_regs(num_regs)
    ) u_regfile (
        .clk  (clk),
        .reset(reset),
        .load (mem_wb_load_regfile),
        .dest (mem_wb_dest),
        .in   (wb_value),
        .src_a(if_id_ir[8:6]),
        .src_b(src_b),
        .reg_a(reg_a),
        .reg_b(reg_b)
    );

    always_ff @(posedge clk) begin
        if (reset || br_taken) begin
            id_ex_ir             <= '0;
            id_ex_load_regfile   <= 1'b0;
            id_ex_load_cc        <= 1'b0;
            id_ex_brmux_sel      <= 1'b0;
            id_ex_regfilemux_sel <= lc3b_ctrl_pkg::regfilemux_alu;
            id_ex_mem_read       <= 1'b0;
            id_ex_mem_write      <= 1'b0;
            id_ex_aluop          <= lc3b_ctrl_pkg::alu_add;
            id_ex_alumux_sel     <= lc3b_ctrl_pkg::alumux_regb;
        end else begin
            id_ex_ir             <= if_id_ir;
            id_ex_load_regfile   <= load_regfile;
            id_ex_load_cc        <= load_cc;
            id_ex_brmux_sel      <= brmux_sel;
            id_ex_regfilemux_sel <= regfilemux_sel;
            id_ex_mem_read       <= mem_read;
            id_ex_mem_write      <= mem_write;
            id_ex_aluop          <= aluop;
            id_ex_alumux_sel     <= alumux_sel;
        end
        id_ex_pc    <= if_id_pc;
        id_ex_reg_a <= reg_a;
        id_ex_reg_b <= reg_b;
    end

    // execute.
    assign imm5    = id_ex_ir[4:0];
    assign offset6 = id_ex_ir[5:0];
    assign offset9 = id_ex_ir[8:0];

    always_comb begin
        case (id_ex_alumux_sel)
            lc3b_ctrl_pkg::alumux_offset6: alu_b = {{9{offset6[5]}}, offset6, 1'b0};
            lc3b_ctrl_pkg::alumux_imm5:    alu_b = {{11{imm5[4]}}, imm5};
            default:                       alu_b = id_ex_reg_b;
        endcase
    end

    alu u_alu (
        .aluop(id_ex_aluop),
        .a    (id_ex_reg_a),
        .b    (alu_b),
        .f    (alu_f)
    );

    // taken when any nzp bit of the br matches.
    assign br_taken  = id_ex_brmux_sel && ((id_ex_ir[11:9] & cc) != 3'b000);
    assign br_target = id_ex_pc + 16'd2 + {{6{offset9[8]}}, offset9, 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem_load_regfile   <= 1'b0;
            ex_mem_load_cc        <= 1'b0;
            ex_mem_regfilemux_sel <= lc3b_ctrl_pkg::regfilemux_alu;
            ex_mem_mem_read       <= 1'b0;
            ex_mem_mem_write      <= 1'b0;
        end else begin
            ex_mem_load_regfile   <= id_ex_load_regfile;
            ex_mem_load_cc        <= id_ex_load_cc;
            ex_mem_regfilemux_sel <= id_ex_regfilemux_sel;
            ex_mem_mem_read       <= id_ex_mem_read;
            ex_mem_mem_write      <= id_ex_mem_write;
        end
        ex_mem_alu   <= alu_f;
        ex_mem_wdata <= id_ex_reg_b;
        ex_mem_dest  <= id_ex_ir[11:9];
    end

    // memory.
    assign dmem_address = ex_mem_alu;
    assign dmem_wdata   = ex_mem_wdata;
    assign dmem_read    = ex_mem_mem_read;
    assign dmem_write   = ex_mem_mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb_load_regfile   <= 1'b0;
            mem_wb_load_cc        <= 1'b0;
            mem_wb_regfilemux_sel <= lc3b_ctrl_pkg::regfilemux_alu;
        end else begin
            mem_wb_load_regfile   <= ex_mem_load_regfile;
            mem_wb_load_cc        <= ex_mem_load_cc;
            mem_wb_regfilemux_sel <= ex_mem_regfilemux_sel;
        end
        mem_wb_alu   <= ex_mem_alu;
        mem_wb_rdata <= dmem_rdata;
        mem_wb_dest  <= ex_mem_dest;
    end

    // writeback.
    assign wb_value = (mem_wb_regfilemux_sel == lc3b_ctrl_pkg::regfilemux_mem) ?
                      mem_wb_rdata : mem_wb_alu;

    always_comb begin
        if (wb_value[15]) begin
            new_cc = 3'b100;
        end else if (wb_value == 16'h0000) begin
            new_cc = 3'b010;
        end else begin
            new_cc = 3'b001;
        end
    end

    // z after reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= 3'b010;
        end else if (mem_wb_load_cc) begin
            cc <= new_cc;
        end
    end

endmodule : lc3b_datapath

// File: src/lc3b_cpu.sv
`timescale 1ns/100ps

module lc3b_cpu #(
    parameter lc3b_isa_pkg::lc3b_word reset_pc = 16'h0000,
    parameter int                     num_regs = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  lc3b_isa_pkg::lc3b_word imem_rdata,
    input  lc3b_isa_pkg::lc3b_word dmem_rdata,
    output lc3b_isa_pkg::lc3b_word imem_address,
    output lc3b_isa_pkg::lc3b_word dmem_address,
    output lc3b_isa_pkg::lc3b_word dmem_wdata,
    output logic                   dmem_read,
    output logic                   dmem_write
);

    lc3b_isa_pkg::lc3b_opcode          opcode;
    logic                              imm_enable;
    logic                              load_regfile;
    logic                              load_cc;
    logic                              brmux_sel;
    logic                              storemux_sel;
    lc3b_ctrl_pkg::lc3b_regfilemux_sel regfilemux_sel;
    logic                              mem_read;
    logic                              mem_write;
    lc3b_ctrl_pkg::lc3b_aluop          aluop;
    lc3b_ctrl_pkg::lc3b_alumux_sel     alumux_sel;

    // decode-stage control.
    control_rom u_control_rom (
        .opcode        (opcode),
        .imm_enable    (imm_enable),
        .load_regfile  (load_regfile),
        .load_cc       (load_cc),
        .brmux_sel     (brmux_sel),
        .storemux_sel  (storemux_sel),
        .regfilemux_sel(regfilemux_sel),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .aluop         (aluop),
        .alumux_sel    (alumux_sel)
    );

    lc3b_datapath #(
        .reset_pc(reset_pc),
        .num_regs(num_regs)
    ) u_datapath (
        .clk           (clk),
        .reset         (reset),
        .imem_rdata    (imem_rdata),
        .dmem_rdata    (dmem_rdata),
        .load_regfile  (load_regfile),
        .load_cc       (load_cc),
        .brmux_sel     (brmux_sel),
        .storemux_sel  (storemux_sel),
        .regfilemux_sel(regfilemux_sel),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .aluop         (aluop),
        .alumux_sel    (alumux_sel),
        .opcode        (opcode),
        .imm_enable    (imm_enable),
        .imem_address  (imem_address),
        .dmem_address  (dmem_address),
        .dmem_wdata    (dmem_wdata),
        .dmem_read     (dmem_read),
        .dmem_write    (dmem_write)
    );

endmodule : lc3b_cpu

// File: dv/lc3b_tb_tasks.svh
`ifndef LC3B_TB_TASKS_SVH
`define LC3B_TB_TASKS_SVH

// instruction encoders.
function automatic lc3b_isa_pkg::lc3b_word alu_reg_instr(
        input lc3b_isa_pkg::lc3b_opcode op, input lc3b_isa_pkg::lc3b_reg dr,
        input lc3b_isa_pkg::lc3b_reg sr1, input lc3b_isa_pkg::lc3b_reg sr2);
    return {op, dr, sr1, 3'b000, sr2};
endfunction

function automatic lc3b_isa_pkg::lc3b_word alu_imm_instr(
        input lc3b_isa_pkg::lc3b_opcode op, input lc3b_isa_pkg::lc3b_reg dr,
        input lc3b_isa_pkg::lc3b_reg sr1, input lc3b_isa_pkg::lc3b_imm5 imm);
    return {op, dr, sr1, 1'b1, imm};
endfunction

function automatic lc3b_isa_pkg::lc3b_word not_instr(
        input lc3b_isa_pkg::lc3b_reg dr, input lc3b_isa_pkg::lc3b_reg sr);
    return {lc3b_isa_pkg::op_not, dr, sr, 6'b111111};
endfunction

// ldr and str share one layout.
function automatic lc3b_isa_pkg::lc3b_word mem_instr(
        input lc3b_isa_pkg::lc3b_opcode op, input lc3b_isa_pkg::lc3b_reg r,
        input lc3b_isa_pkg::lc3b_reg base, input lc3b_isa_pkg::lc3b_offset6 off);
    return {op, r, base, off};
endfunction

function automatic lc3b_isa_pkg::lc3b_word br_instr(
        input lc3b_isa_pkg::lc3b_nzp cond, input lc3b_isa_pkg::lc3b_offset9 off);
    return {lc3b_isa_pkg::op_br, cond, off};
endfunction

// expected values from the isa rules.
function automatic lc3b_isa_pkg::lc3b_word imm_value(input lc3b_isa_pkg::lc3b_imm5 imm);
    return lc3b_isa_pkg::lc3b_word'(int'($signed(imm)));
endfunction

function automatic lc3b_isa_pkg::lc3b_word store_address(
        input lc3b_isa_pkg::lc3b_word base, input lc3b_isa_pkg::lc3b_offset6 off);
    return base + lc3b_isa_pkg::lc3b_word'(2 * int'($signed(off)));
endfunction

task automatic check_word(input string name, input lc3b_isa_pkg::lc3b_word expected,
        input lc3b_isa_pkg::lc3b_word actual);
    if (actual !== expected) begin
        $display("MISMATCH %s: data expected %h, actual %h", name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_address(input string name, input lc3b_isa_pkg::lc3b_word expected,
        input lc3b_isa_pkg::lc3b_word actual);
    if (actual !== expected) begin
        $display("MISMATCH %s: address expected %h, actual %h", name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_count(input string name, input string kind, input int expected,
        input int actual);
    if (actual != expected) begin
        $display("MISMATCH %s: %s count expected %0d, actual %0d", name, kind, expected,
                 actual);
        test_errors++;
    end
endtask

task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_load.delete();
    test_errors = 0;
endtask

task automatic emit(input lc3b_isa_pkg::lc3b_word instr);
    prog.push_back(instr);
endtask

// three no-ops cover both the register and the cc distance.
task automatic insert_gap();
    repeat (3) prog.push_back(16'h0000);
endtask

task automatic expect_store(input lc3b_isa_pkg::lc3b_word addr,
        input lc3b_isa_pkg::lc3b_word data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

task automatic expect_load(input lc3b_isa_pkg::lc3b_word addr);
    exp_load.push_back(addr);
endtask

task automatic run_program(input string name);
    int words;
    int i;
    // program ends in a branch to itself.
    prog.push_back(br_instr(3'b111, 9'h1ff));
    words = prog.size();
    @(negedge clk);
    reset = 1'b1;
    if (words > prog_words) begin
        $display("%s: program of %0d words is longer than %0d", name, words, prog_words);
        test_errors++;
        words = prog_words;
    end
    for (i = 0; i < imem_words; i++) begin
        imem[i] = 16'h0000;
    end
    for (i = 0; i < words; i++) begin
        imem[reset_pc[8:1] + i] = prog[i];
    end
    store_addr.delete();
    store_data.delete();
    load_addr.delete();
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    check_address(name, reset_pc, imem_address);
    repeat (words + 10) @(negedge clk);
    check_count(name, "store", exp_addr.size(), store_addr.size());
    for (i = 0; i < exp_addr.size() && i < store_addr.size(); i++) begin
        check_address(name, exp_addr[i], store_addr[i]);
        check_word(name, exp_data[i], store_data[i]);
    end
    check_count(name, "load", exp_load.size(), load_addr.size());
    for (i = 0; i < exp_load.size() && i < load_addr.size(); i++) begin
        check_address(name, exp_load[i], load_addr[i]);
    end
    tests_run++;
    error_count += test_errors;
    if (test_errors != 0) begin
        tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
endtask

`endif

// File: dv/lc3b_tb.sv
`timescale 1ns/100ps

module lc3b_tb;

    localparam lc3b_isa_pkg::lc3b_word reset_pc = 16'h0040;
    localparam int reset_cycles = 3;
    localparam int imem_words   = 256;
    localparam int dmem_words   = 256;
    localparam int prog_words   = 64;
    localparam int num_tests    = 5;
    // reset, program, drain and one spare cycle per test.
    localparam int cycle_limit  = num_tests * (reset_cycles + prog_words + 12) + 100;

    logic                   clk;
    logic                   reset;
    lc3b_isa_pkg::lc3b_word imem_address;
    lc3b_isa_pkg::lc3b_word imem_rdata;
    lc3b_isa_pkg::lc3b_word dmem_address;
    lc3b_isa_pkg::lc3b_word dmem_wdata;
    lc3b_isa_pkg::lc3b_word dmem_rdata;
    logic                   dmem_read;
    logic                   dmem_write;

    lc3b_isa_pkg::lc3b_word imem [imem_words];
    lc3b_isa_pkg::lc3b_word dmem [dmem_words];

    lc3b_isa_pkg::lc3b_word prog [$];
    lc3b_isa_pkg::lc3b_word exp_addr [$];
    lc3b_isa_pkg::lc3b_word exp_data [$];
    lc3b_isa_pkg::lc3b_word exp_load [$];
    lc3b_isa_pkg::lc3b_word store_addr [$];
    lc3b_isa_pkg::lc3b_word store_data [$];
    lc3b_isa_pkg::lc3b_word load_addr [$];

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          test_errors;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    `include "lc3b_tb_tasks.svh"

    lc3b_cpu #(
        .reset_pc(reset_pc),
        .num_regs(8)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .imem_rdata  (imem_rdata),
        .dmem_rdata  (dmem_rdata),
        .imem_address(imem_address),
        .dmem_address(dmem_address),
        .dmem_wdata  (dmem_wdata),
        .dmem_read   (dmem_read),
        .dmem_write  (dmem_write)
    );

    always #10 clk = ~clk;

    // both memories answer in the same cycle.
    assign imem_rdata = imem[imem_address[8:1]];
    assign dmem_rdata = dmem[dmem_address[8:1]];

    // stores and loads are logged mid-cycle, in program order.
    always @(negedge clk) begin
        if (dmem_write === 1'b1) begin
            store_addr.push_back(dmem_address);
            store_data.push_back(dmem_wdata);
            dmem[dmem_address[8:1]] = dmem_wdata;
        end
        if (dmem_read === 1'b1) begin
            load_addr.push_back(dmem_address);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    // galois lfsr, one step per bit.
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'ha3000000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic test_reset();
        lc3b_isa_pkg::lc3b_imm5 a;
        new_program();
        a = random_bits(5);
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd1, 3'd0, a));
        emit(not_instr(3'd2, 3'd0));
        insert_gap();
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd1, 3'd0, 6'd7));
        expect_store(store_address(16'h0000, 6'd7), imm_value(a));
        run_program("reset");
    endtask

    task automatic test_add();
        lc3b_isa_pkg::lc3b_imm5 a;
        lc3b_isa_pkg::lc3b_imm5 b;
        lc3b_isa_pkg::lc3b_imm5 c;
        lc3b_isa_pkg::lc3b_imm5 d;
        new_program();
        a = random_bits(5);
        b = random_bits(5);
        c = random_bits(5);
        d = random_bits(5);
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd1, 3'd0, a));
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd2, 3'd0, b));
        insert_gap();
        emit(alu_reg_instr(lc3b_isa_pkg::op_add, 3'd3, 3'd1, 3'd2));
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd4, 3'd1, c));
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd5, 3'd2, d));
        insert_gap();
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd1, 3'd0, 6'd1));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd3, 3'd0, 6'd2));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd4, 3'd0, 6'd3));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd5, 3'd0, 6'd4));
        expect_store(store_address(16'h0000, 6'd1), imm_value(a));
        expect_store(store_address(16'h0000, 6'd2), imm_value(a) + imm_value(b));
        expect_store(store_address(16'h0000, 6'd3), imm_value(a) + imm_value(c));
        expect_store(store_address(16'h0000, 6'd4), imm_value(b) + imm_value(d));
        run_program("add");
    endtask

    task automatic test_logic();
        lc3b_isa_pkg::lc3b_imm5 a;
        lc3b_isa_pkg::lc3b_imm5 b;
        lc3b_isa_pkg::lc3b_imm5 c;
        new_program();
        a = random_bits(5);
        b = random_bits(5);
        c = random_bits(5);
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd1, 3'd0, a));
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd2, 3'd0, b));
        insert_gap();
        emit(alu_reg_instr(lc3b_isa_pkg::op_and, 3'd3, 3'd1, 3'd2));
        emit(alu_imm_instr(lc3b_isa_pkg::op_and, 3'd4, 3'd1, c));
        emit(not_instr(3'd5, 3'd1));
        emit(not_instr(3'd6, 3'd2));
        insert_gap();
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd3, 3'd0, 6'd8));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd4, 3'd0, 6'd9));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd5, 3'd0, 6'd10));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd6, 3'd0, 6'd11));
        expect_store(store_address(16'h0000, 6'd8), imm_value(a) & imm_value(b));
        expect_store(store_address(16'h0000, 6'd9), imm_value(a) & imm_value(c));
        expect_store(store_address(16'h0000, 6'd10), ~imm_value(a));
        expect_store(store_address(16'h0000, 6'd11), ~imm_value(b));
        run_program("and_not");
    endtask

    task automatic test_load();
        lc3b_isa_pkg::lc3b_word w [4];
        lc3b_isa_pkg::lc3b_word far_addr;
        for (int i = 0; i < 4; i++) begin
            w[i] = random_bits(16);
        end
        new_program();
        // three words at offsets 24 to 26, one below a base of 8.
        far_addr = store_address(16'd8, 6'h3e);
        dmem[24] = w[0];
        dmem[25] = w[1];
        dmem[26] = w[2];
        dmem[far_addr[8:1]] = w[3];
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd5, 3'd0, 5'd8));
        emit(mem_instr(lc3b_isa_pkg::op_ldr, 3'd1, 3'd0, 6'd24));
        emit(mem_instr(lc3b_isa_pkg::op_ldr, 3'd2, 3'd0, 6'd25));
        emit(mem_instr(lc3b_isa_pkg::op_ldr, 3'd3, 3'd0, 6'd26));
        emit(mem_instr(lc3b_isa_pkg::op_ldr, 3'd6, 3'd5, 6'h3e));
        insert_gap();
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd1, 3'd0, 6'd28));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd2, 3'd0, 6'd29));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd3, 3'd0, 6'd30));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd6, 3'd0, 6'd31));
        expect_load(store_address(16'h0000, 6'd24));
        expect_load(store_address(16'h0000, 6'd25));
        expect_load(store_address(16'h0000, 6'd26));
        expect_load(far_addr);
        expect_store(store_address(16'h0000, 6'd28), w[0]);
        expect_store(store_address(16'h0000, 6'd29), w[1]);
        expect_store(store_address(16'h0000, 6'd30), w[2]);
        expect_store(store_address(16'h0000, 6'd31), w[3]);
        run_program("load");
    endtask

    // add sets cc, then a branch over two stores to a third.
    task automatic branch_case(input lc3b_isa_pkg::lc3b_imm5 imm,
            input lc3b_isa_pkg::lc3b_nzp cond, input lc3b_isa_pkg::lc3b_offset6 off);
        lc3b_isa_pkg::lc3b_word value;
        lc3b_isa_pkg::lc3b_nzp  flags;
        value = imm_value(imm);
        if ($signed(value) < 0) begin
            flags = 3'b100;
        end else if (value == 16'h0000) begin
            flags = 3'b010;
        end else begin
            flags = 3'b001;
        end
        emit(alu_imm_instr(lc3b_isa_pkg::op_add, 3'd1, 3'd0, imm));
        insert_gap();
        emit(br_instr(cond, 9'd2));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd1, 3'd0, off));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd1, 3'd0, off + 6'd1));
        emit(mem_instr(lc3b_isa_pkg::op_str, 3'd1, 3'd0, off + 6'd2));
        if ((cond & flags) == 3'b000) begin
            expect_store(store_address(16'h0000, off), value);
            expect_store(store_address(16'h0000, off + 6'd1), value);
        end
        expect_store(store_address(16'h0000, off + 6'd2), value);
    endtask

    task automatic test_branch();
        logic [3:0] neg_mag;
        logic [3:0] pos_mag;
        neg_mag = random_bits(4);
        pos_mag = random_bits(4);
        new_program();
        branch_case({1'b1, neg_mag}, 3'b100, 6'd0);
        branch_case({1'b1, neg_mag}, 3'b011, 6'd3);
        branch_case(5'd0, 3'b010, 6'd6);
        branch_case(5'd0, 3'b101, 6'd9);
        branch_case({1'b0, pos_mag | 4'b0001}, 3'b001, 6'd12);
        branch_case({1'b0, pos_mag | 4'b0001}, 3'b110, 6'd15);
        run_program("branch");
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        lfsr_state   = 32'h009e9334;
        cycle_count  = 0;
        test_errors  = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = 16'h0000;
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = 16'(i * 2) ^ 16'h5ac3;
        end

        test_reset();
        test_add();
        test_logic();
        test_load();
        test_branch();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : lc3b_tb

// File: filelist.f
+incdir+dv
common/lc3b_isa_pkg.sv
common/lc3b_ctrl_pkg.sv
src/control_rom.sv
src/regfile.sv
src/alu.sv
src/lc3b_datapath.sv
src/lc3b_cpu.sv
dv/lc3b_tb.sv

// File: Bender.yml
package:
  name: lc3b_core

sources:
  # packages first, then the rtl bottom up.
  - common/lc3b_isa_pkg.sv
  - common/lc3b_ctrl_pkg.sv
  - src/control_rom.sv
  - src/regfile.sv
  - src/alu.sv
  - src/lc3b_datapath.sv
  - src/lc3b_cpu.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/lc3b_tb.sv
